/* source/lsu_params.svh */
// Width, access size code and data RAM region macros
// Shared by the load/store unit package and RTL
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

`define LSU_WORD_WIDTH      32              // Data and address word
`define LSU_SEL_WIDTH       4               // One select bit per byte lane

// Access size codes
`define LSU_SIZE_BYTE       2'b00
`define LSU_SIZE_HWORD      2'b11
`define LSU_SIZE_WORD       2'b10

// Data RAM region, inclusive byte bounds
`define LSU_DRAM_BASE       32'h0000_0000
`define LSU_DRAM_LIMIT      32'h0000_00ff
`define LSU_DRAM_ADDR_WIDTH 6               // 64 words

`endif

/* source/lsu_pkg.sv */
// Load/store unit types
// Access size enum and the loaded-word union
`include "lsu_params.svh"

package lsu_pkg;

    // Access size, codes from the params header
    typedef enum logic [1:0]
    {
        SIZE_BYTE  = `LSU_SIZE_BYTE,
        SIZE_HWORD = `LSU_SIZE_HWORD,
        SIZE_WORD  = `LSU_SIZE_WORD
    } size_e;

    // Loaded word, big-endian
    // bytes[3] and halves[1] sit at offset 0
    typedef union packed
    {
        logic [`LSU_SEL_WIDTH-1:0][7:0] bytes;    // Byte loads
        logic [1:0][15:0]               halves;   // Half-word loads
    } load_word_u;

endpackage

/* source/lsu_stage_if.sv */
// M-stage access bundle
// Driven by the X/M registers, read by RAM, bus master and aligner
`timescale 1ns/1ps
`include "lsu_params.svh"

interface lsu_stage_if (input logic clk_i);
    import lsu_pkg::*;

    size_e                      size_m;          // Access size in M
    logic                       sign_extend_m;   // Sign or zero extend the load
    logic [`LSU_SEL_WIDTH-1:0]  byte_enable_m;   // Lanes touched by the access
    logic [`LSU_WORD_WIDTH-1:0] store_data_m;    // Lane-replicated store data
    logic                       dram_select_m;   // Access hits the data RAM
    logic                       bus_select_m;    // Access goes to Wishbone

    // X/M register side
    modport xm (input clk_i, output size_m, sign_extend_m, byte_enable_m,
        store_data_m, dram_select_m, bus_select_m);

    // Memory side, RAM and bus master
    modport mem (input clk_i, size_m, sign_extend_m, byte_enable_m,
        store_data_m, dram_select_m, bus_select_m);

    // Load aligner only needs source and extraction info
    modport align (input clk_i, size_m, sign_extend_m, dram_select_m);

endinterface

/* source/lsu_xm_stage.sv */
// X-stage store lane replication, byte enables and region decode
// X/M pipeline registers feeding the stage interface
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_xm_stage
(
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       stall_m_i,
    input  lsu_pkg::size_e             size_x_i,
    input  logic                       sign_extend_x_i,
    input  logic [`LSU_WORD_WIDTH-1:0] store_operand_x_i,
    input  logic [`LSU_WORD_WIDTH-1:0] address_x_i,
    lsu_stage_if.xm                    stage,
    output logic                       bus_select_x_o
);
    import lsu_pkg::*;

    logic [`LSU_WORD_WIDTH-1:0] store_data_x;
    logic [`LSU_SEL_WIDTH-1:0]  byte_enable_x;
    logic [`LSU_WORD_WIDTH-1:0] dram_offset_x;   // Distance above region base
    logic                       dram_select_x;

    ////////////////////////////////////////////////////////////////////////////
    // X-stage decode
    ////////////////////////////////////////////////////////////////////////////

    // Copy the operand into every lane it may land in
    always_comb
    begin
        case (size_x_i)
            SIZE_BYTE:  store_data_x = {4{store_operand_x_i[7:0]}};
            SIZE_HWORD: store_data_x = {2{store_operand_x_i[15:0]}};
            default:    store_data_x = store_operand_x_i;
        endcase
    end

    // Offset 0 is the top lane
    always_comb
    begin
        case (size_x_i)
            SIZE_BYTE:  byte_enable_x = 4'b1000 >> address_x_i[1:0];
            SIZE_HWORD: byte_enable_x = address_x_i[1] ? 4'b0011 : 4'b1100;
            default:    byte_enable_x = 4'b1111;
        endcase
    end

    // Unsigned distance check also catches addresses below base
    assign dram_offset_x  = address_x_i - `LSU_DRAM_BASE;
    assign dram_select_x  = dram_offset_x <= (`LSU_DRAM_LIMIT - `LSU_DRAM_BASE);
    assign bus_select_x_o = !dram_select_x;   // Early for the load stall

    ////////////////////////////////////////////////////////////////////////////
    // X/M registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            stage.size_m        <= SIZE_BYTE;
            stage.sign_extend_m <= 1'b0;
            stage.byte_enable_m <= '0;
            stage.dram_select_m <= 1'b0;
            stage.bus_select_m  <= 1'b0;
        end
        else if (!stall_m_i)
        begin
            stage.size_m        <= size_x_i;
            stage.sign_extend_m <= sign_extend_x_i;
            stage.byte_enable_m <= byte_enable_x;
            stage.dram_select_m <= dram_select_x;
            stage.bus_select_m  <= bus_select_x_o;
        end
    end

    // Store payload
    always_ff @(posedge clk_i)
    begin
        if (!stall_m_i)
            stage.store_data_m <= store_data_x;
    end

endmodule

/* source/lsu_dram.sv */
// Local data RAM, 64 words
// X-stage read, M-stage read-modify-write of enabled bytes
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_dram
(
    input  logic                       clk_i,
    input  logic                       stall_x_i,
    input  logic                       stall_m_i,
    input  logic                       store_q_m_i,
    input  logic [`LSU_WORD_WIDTH-1:0] address_x_i,
    input  logic [`LSU_WORD_WIDTH-1:0] address_m_i,
    lsu_stage_if.mem                   stage,
    output logic [`LSU_WORD_WIDTH-1:0] dram_data_m_o
);
    localparam int DEPTH = 1 << `LSU_DRAM_ADDR_WIDTH;

    logic [`LSU_WORD_WIDTH-1:0]     mem_q [0:DEPTH-1];
    logic [`LSU_DRAM_ADDR_WIDTH-1:0] rd_addr;
    logic [`LSU_DRAM_ADDR_WIDTH-1:0] wr_addr;
    logic                           wr_en;
    logic [`LSU_WORD_WIDTH-1:0]     merged_m;   // Old word with store lanes swapped in

    assign rd_addr = address_x_i[`LSU_DRAM_ADDR_WIDTH+1:2];   // Word address
    assign wr_addr = address_m_i[`LSU_DRAM_ADDR_WIDTH+1:2];
    assign wr_en   = store_q_m_i && stage.dram_select_m && !stall_m_i;

    // Word read for this store came out when it left X
    always_comb
    begin
        for (int i = 0; i < `LSU_SEL_WIDTH; i++)
            merged_m[i*8 +: 8] = stage.byte_enable_m[i] ? stage.store_data_m[i*8 +: 8]
                                                        : dram_data_m_o[i*8 +: 8];
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_en)
            mem_q[wr_addr] <= merged_m;
        if (!stall_x_i)
        begin
            // Forward a same-edge write to the same word
            if (wr_en && (wr_addr == rd_addr))
                dram_data_m_o <= merged_m;
            else
                dram_data_m_o <= mem_q[rd_addr];
        end
    end

endmodule

/* source/lsu_wb_master.sv */
// Wishbone classic single-access master
// Read data register, load-complete flag and bus load stall request
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_wb_master
(
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       stall_x_i,
    input  logic                       stall_m_i,
    input  logic                       kill_m_i,
    input  logic                       load_q_x_i,
    input  logic                       load_q_m_i,
    input  logic                       store_q_m_i,
    input  logic                       bus_select_x_i,
    input  logic [`LSU_WORD_WIDTH-1:0] address_m_i,
    lsu_stage_if.mem                   stage,
    input  logic [`LSU_WORD_WIDTH-1:0] d_dat_i,
    input  logic                       d_ack_i,
    input  logic                       d_err_i,
    output logic [`LSU_WORD_WIDTH-1:0] d_dat_o,
    output logic [`LSU_WORD_WIDTH-1:0] d_adr_o,
    output logic [`LSU_SEL_WIDTH-1:0]  d_sel_o,
    output logic                       d_cyc_o,
    output logic                       d_stb_o,
    output logic                       d_we_o,
    output logic [`LSU_WORD_WIDTH-1:0] wb_data_m_o,
    output logic                       stall_wb_load_o
);
    logic load_complete;   // Read for the load in M has returned
    logic cycle_done;
    logic start_write;
    logic start_read;

    // Error ends the cycle like ack
    assign cycle_done  = d_cyc_o && (d_ack_i || d_err_i);
    // Write-through, starts as the store leaves M
    assign start_write = !d_cyc_o && store_q_m_i && stage.bus_select_m && !stall_m_i;
    // Load sits stalled in M until its read returns
    assign start_read  = !d_cyc_o && !start_write && load_q_m_i && stage.bus_select_m
                         && !load_complete && !kill_m_i;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            d_cyc_o         <= 1'b0;
            d_stb_o         <= 1'b0;
            d_we_o          <= 1'b0;
            load_complete   <= 1'b0;
            stall_wb_load_o <= 1'b0;
        end
        else
        begin
            if (cycle_done)
            begin
                d_cyc_o       <= 1'b0;
                d_stb_o       <= 1'b0;
                load_complete <= !d_we_o;   // Writes never complete a load
            end
            else if (start_write || start_read)
            begin
                d_cyc_o <= 1'b1;
                d_stb_o <= 1'b1;
                d_we_o  <= start_write;
            end

            if (!stall_m_i)
                load_complete <= 1'b0;   // Load has moved on to W

            // Later assignments win, kill has the last word
            if (start_read)
                stall_wb_load_o <= 1'b0;
            if (load_q_x_i && bus_select_x_i && !stall_x_i)
                stall_wb_load_o <= 1'b1;
            if (kill_m_i)
                stall_wb_load_o <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus payload and read data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (start_write || start_read)
        begin
            d_adr_o <= address_m_i;
            d_sel_o <= stage.byte_enable_m;
        end
        if (start_write)
            d_dat_o <= stage.store_data_m;
        if (cycle_done && !d_we_o)
            wb_data_m_o <= d_dat_i;   // Held until the load leaves M
    end

endmodule

/* source/lsu_load_align.sv */
// M-stage load source select and M/W registers
// W-stage sub-word extraction with sign or zero extension
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_load_align
(
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    lsu_stage_if.align                 stage,
    input  logic [`LSU_WORD_WIDTH-1:0] dram_data_m_i,
    input  logic [`LSU_WORD_WIDTH-1:0] wb_data_m_i,
    input  logic [1:0]                 address_w_i,
    output logic [`LSU_WORD_WIDTH-1:0] load_data_w_o
);
    import lsu_pkg::*;

    logic [`LSU_WORD_WIDTH-1:0] data_m;
    load_word_u                 data_w;
    size_e                      size_w;
    logic                       sign_extend_w;
    logic [7:0]                 byte_w;   // Addressed byte
    logic [15:0]                half_w;   // Addressed half word

    assign data_m = stage.dram_select_m ? dram_data_m_i : wb_data_m_i;

    // M/W registers, load every cycle
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            size_w        <= SIZE_BYTE;
            sign_extend_w <= 1'b0;
        end
        else
        begin
            size_w        <= stage.size_m;
            sign_extend_w <= stage.sign_extend_m;
        end
    end

    always_ff @(posedge clk_i)
        data_w <= data_m;

    // Big-endian, offset 0 picks the top byte or half
    assign byte_w = data_w.bytes[2'd3 - address_w_i];
    assign half_w = data_w.halves[!address_w_i[1]];

    always_comb
    begin
        case (size_w)
            SIZE_BYTE:  load_data_w_o = {{24{sign_extend_w & byte_w[7]}}, byte_w};
            SIZE_HWORD: load_data_w_o = {{16{sign_extend_w & half_w[15]}}, half_w};
            default:    load_data_w_o = data_w;
        endcase
    end

endmodule

/* source/lsu_top.sv */
// Load/store unit top level
// Wires the X/M stage, data RAM, Wishbone master and load aligner
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_top
(
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    // Pipeline
    input  logic                       stall_x_i,
    input  logic                       stall_m_i,
    input  logic                       kill_m_i,
    input  logic                       load_q_x_i,
    input  logic                       load_q_m_i,
    input  logic                       store_q_m_i,
    input  lsu_pkg::size_e             size_x_i,
    input  logic                       sign_extend_x_i,
    input  logic [`LSU_WORD_WIDTH-1:0] store_operand_x_i,
    input  logic [`LSU_WORD_WIDTH-1:0] address_x_i,
    input  logic [`LSU_WORD_WIDTH-1:0] address_m_i,
    input  logic [1:0]                 address_w_i,
    output logic [`LSU_WORD_WIDTH-1:0] load_data_w_o,
    output logic                       stall_wb_load_o,
    // Wishbone
    input  logic [`LSU_WORD_WIDTH-1:0] d_dat_i,
    input  logic                       d_ack_i,
    input  logic                       d_err_i,
    output logic [`LSU_WORD_WIDTH-1:0] d_dat_o,
    output logic [`LSU_WORD_WIDTH-1:0] d_adr_o,
    output logic [`LSU_SEL_WIDTH-1:0]  d_sel_o,
    output logic                       d_cyc_o,
    output logic                       d_stb_o,
    output logic                       d_we_o
);
    logic                       bus_select_x;   // Combinational, for the stall
    logic [`LSU_WORD_WIDTH-1:0] dram_data_m;
    logic [`LSU_WORD_WIDTH-1:0] wb_data_m;

    lsu_stage_if stage_if_i (.clk_i(clk_i));

    lsu_xm_stage xm_stage_i
    (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_m_i(stall_m_i),
        .size_x_i(size_x_i), .sign_extend_x_i(sign_extend_x_i),
        .store_operand_x_i(store_operand_x_i), .address_x_i(address_x_i),
        .stage(stage_if_i.xm), .bus_select_x_o(bus_select_x)
    );

    lsu_dram dram_i
    (
        .clk_i(clk_i), .stall_x_i(stall_x_i), .stall_m_i(stall_m_i),
        .store_q_m_i(store_q_m_i), .address_x_i(address_x_i),
        .address_m_i(address_m_i), .stage(stage_if_i.mem),
        .dram_data_m_o(dram_data_m)
    );

    lsu_wb_master wb_master_i
    (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_x_i(stall_x_i),
        .stall_m_i(stall_m_i), .kill_m_i(kill_m_i), .load_q_x_i(load_q_x_i),
        .load_q_m_i(load_q_m_i), .store_q_m_i(store_q_m_i),
        .bus_select_x_i(bus_select_x), .address_m_i(address_m_i),
        .stage(stage_if_i.mem), .d_dat_i(d_dat_i), .d_ack_i(d_ack_i),
        .d_err_i(d_err_i), .d_dat_o(d_dat_o), .d_adr_o(d_adr_o),
        .d_sel_o(d_sel_o), .d_cyc_o(d_cyc_o), .d_stb_o(d_stb_o), .d_we_o(d_we_o),
        .wb_data_m_o(wb_data_m), .stall_wb_load_o(stall_wb_load_o)
    );

    lsu_load_align load_align_i
    (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stage(stage_if_i.align),
        .dram_data_m_i(dram_data_m), .wb_data_m_i(wb_data_m),
        .address_w_i(address_w_i), .load_data_w_o(load_data_w_o)
    );

endmodule

/* verification/lsu_checker.sv */
// Concurrent assertions on the Wishbone master
// Cycle framing, stable address phase, reset state and load stall
`timescale 1ns/1ps

module lsu_checker
(
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        d_cyc_o,
    input logic        d_stb_o,
    input logic        d_ack_i,
    input logic        d_err_i,
    input logic [31:0] d_adr_o,
    input logic [3:0]  d_sel_o,
    input logic        stall_wb_load_o
);
    // Classic single access, strobe tracks cycle
    cyc_stb_equal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        d_cyc_o == d_stb_o) else $error("cyc and stb differ");

    // Address phase held while the slave waits
    adr_sel_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        d_cyc_o && !(d_ack_i || d_err_i) |=> $stable(d_adr_o) && $stable(d_sel_o))
        else $error("address or select changed during a waiting cycle");

    cyc_low_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> !d_cyc_o) else $error("cyc high during reset");

    // Stall request drops once the read is on the bus
    no_stall_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        d_cyc_o |-> !stall_wb_load_o) else $error("load stall high during a bus cycle");

endmodule

bind lsu_wb_master lsu_checker checker_i (.*);

/* verification/lsu_tb.sv */
// Load/store unit testbench
// Pipeline driver, Wishbone slave model, byte reference model and watchdog
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int          RAM_WORDS  = 1 << `LSU_DRAM_ADDR_WIDTH;
    localparam int          NUM_RANDOM = 300;
    localparam int          NUM_INSTR  = RAM_WORDS + NUM_RANDOM;
    localparam logic [31:0] BUS_BASE   = 32'h0000_1000;   // 1 KiB bus window

    logic clk_i, arst_n_i, stall_x_i, stall_m_i, kill_m_i;
    logic load_q_x_i, load_q_m_i, store_q_m_i, sign_extend_x_i;
    size_e size_x_i;
    logic [31:0] store_operand_x_i, address_x_i, address_m_i, load_data_w_o;
    logic [1:0]  address_w_i;
    logic        stall_wb_load_o, d_cyc_o, d_stb_o, d_we_o;
    logic [31:0] d_dat_i = '0;
    logic        d_ack_i = 1'b0;
    logic        d_err_i = 1'b0;
    logic [31:0] d_dat_o, d_adr_o;
    logic [3:0]  d_sel_o;

    logic [7:0]  ram_ref [0:255];    // Byte model of the data RAM
    logic [7:0]  bus_ref [0:1023];   // Byte model of the bus window
    logic [31:0] bus_mem [0:255];    // Slave storage
    logic [31:0] lfsr_q, wait_lfsr, r;
    logic [1:0]  wait_cnt;
    int          checks, errors, mark;

    lsu_top lsu_top_i (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] bus_pattern(input int i);
        return (BUS_BASE + i * 4) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;   // Whole address
    endfunction

    function automatic logic [7:0] get_byte(input logic [31:0] a);
        return (a >= BUS_BASE) ? bus_ref[a[9:0]] : ram_ref[a[7:0]];
    endfunction

    function automatic int size_bytes(input size_e s);
        return (s == SIZE_BYTE) ? 1 : (s == SIZE_HWORD) ? 2 : 4;
    endfunction

    // Big-endian so offset 0 holds the most significant byte
    function automatic logic [31:0] expect_load(input size_e s, input logic sx,
                                                input logic [31:0] a);
        logic [31:0] v;
        case (s)
            SIZE_BYTE:
            begin
                v = {24'b0, get_byte(a)};
                if (sx && v[7]) v[31:8] = '1;
            end
            SIZE_HWORD:
            begin
                v = {16'b0, get_byte(a), get_byte(a + 1)};
                if (sx && v[15]) v[31:16] = '1;
            end
            default: v = {get_byte(a), get_byte(a + 1), get_byte(a + 2), get_byte(a + 3)};
        endcase
        return v;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s done, %0d errors", name, errors - mark);
        mark = errors;
    endtask

    // One instruction through X, M and W with nothing else in flight
    task automatic run_access(input logic is_load, input size_e s, input logic sx,
                              input logic [31:0] addr, input logic [31:0] op,
                              input logic kill);
        logic       is_bus;
        logic [3:0] exp_sel;
        int         n, off;
        is_bus  = addr >= BUS_BASE;
        n       = size_bytes(s);
        off     = int'(addr[1:0]);
        exp_sel = '0;
        @(posedge clk_i);   // Into X
        load_q_x_i        <= is_load;
        size_x_i          <= s;
        sign_extend_x_i   <= sx;
        store_operand_x_i <= op;
        address_x_i       <= addr;
        @(posedge clk_i);   // Into M
        load_q_x_i  <= 1'b0;
        address_x_i <= '0;
        load_q_m_i  <= is_load;
        store_q_m_i <= !is_load;
        address_m_i <= addr;
        kill_m_i    <= kill;
        stall_m_i   <= is_load && is_bus;   // Pipeline follows the stall request
        stall_x_i   <= is_load && is_bus;
        @(negedge clk_i);
        check_bit(stall_wb_load_o, is_load && is_bus, "load stall after X");
        check_bit(d_cyc_o, 1'b0, "cyc while access enters M");
        if (!is_load)
        begin
            for (int k = 0; k < n; k++)
            begin
                exp_sel[3 - off - k] = 1'b1;
                if (is_bus) bus_ref[addr[9:0] + k] = op[(n - 1 - k) * 8 +: 8];
                else        ram_ref[addr[7:0] + k] = op[(n - 1 - k) * 8 +: 8];
            end
            @(posedge clk_i);   // Store leaves M
            store_q_m_i <= 1'b0;
            if (is_bus)
            begin
                @(negedge clk_i);
                check_bit(d_cyc_o, 1'b1, "write cycle start");
                check_bit(d_we_o, 1'b1, "write enable");
                check_word(d_adr_o, addr, "write address");
                check_word({28'b0, d_sel_o}, {28'b0, exp_sel}, "write select");
                for (int k = 0; k < n; k++)
                    check_word({24'b0, d_dat_o[(3 - off - k) * 8 +: 8]},
                               {24'b0, op[(n - 1 - k) * 8 +: 8]}, "write lane");
                while (d_cyc_o) @(negedge clk_i);
            end
        end
        else if (kill)
        begin
            @(posedge clk_i);   // Killed load leaves the pipeline
            load_q_m_i <= 1'b0;
            kill_m_i   <= 1'b0;
            stall_m_i  <= 1'b0;
            stall_x_i  <= 1'b0;
            @(negedge clk_i);
            check_bit(stall_wb_load_o, 1'b0, "stall after kill");
            check_bit(d_cyc_o, 1'b0, "cyc after kill");
            @(negedge clk_i);
            check_bit(d_cyc_o, 1'b0, "cyc after kill, next cycle");
        end
        else
        begin
            if (is_bus)
            begin
                @(negedge clk_i);
                check_bit(d_cyc_o, 1'b1, "read cycle start");
                check_bit(d_we_o, 1'b0, "read enable");
                check_bit(stall_wb_load_o, 1'b0, "stall at read start");
                check_word(d_adr_o, addr, "read address");
                while (d_cyc_o) @(negedge clk_i);
                @(posedge clk_i);   // Release the pipeline
                stall_m_i <= 1'b0;
                stall_x_i <= 1'b0;
            end
            @(posedge clk_i);   // Load leaves M into W
            load_q_m_i  <= 1'b0;
            address_w_i <= addr[1:0];
            @(negedge clk_i);
            check_word(load_data_w_o, expect_load(s, sx, addr), "load data in W");
        end
    endtask

    // Wishbone slave with 0 to 3 wait cycles
    always @(posedge clk_i)
    begin
        d_ack_i <= 1'b0;
        d_err_i <= 1'b0;
        if (!arst_n_i)
        begin
            wait_lfsr = 32'he9826b9d;
            wait_cnt <= 2'd0;
            for (int i = 0; i < 256; i++)
                bus_mem[i] <= bus_pattern(i);
        end
        else if (d_cyc_o && d_stb_o && !d_ack_i && !d_err_i)
        begin
            if (wait_cnt == 2'd0)
            begin
                wait_lfsr = lfsr_next(wait_lfsr);
                if (wait_lfsr[0])
                    d_err_i <= 1'b1;   // Errors complete the transfer too
                else
                    d_ack_i <= 1'b1;
                if (d_we_o)
                begin
                    for (int i = 0; i < 4; i++)
                        if (d_sel_o[i])
                            bus_mem[d_adr_o[9:2]][i * 8 +: 8] <= d_dat_o[i * 8 +: 8];
                end
                else
                    d_dat_i <= bus_mem[d_adr_o[9:2]];
                wait_lfsr = lfsr_next(wait_lfsr);
                wait_lfsr = lfsr_next(wait_lfsr);
                wait_cnt <= wait_lfsr[1:0];   // Two steps for two bits
            end
            else
                wait_cnt <= wait_cnt - 2'd1;
        end
    end

    // Watchdog allows 10 cycles per instruction
    initial
    begin
        #(NUM_INSTR * 10 * 100);
        $display("Timeout: the run did not finish within %0d cycles", NUM_INSTR * 10);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        clk_i             = 1'b0;
        arst_n_i          = 1'b0;
        stall_x_i         = 1'b0;
        stall_m_i         = 1'b0;
        kill_m_i          = 1'b0;
        load_q_x_i        = 1'b0;
        load_q_m_i        = 1'b0;
        store_q_m_i       = 1'b0;
        size_x_i          = SIZE_WORD;
        sign_extend_x_i   = 1'b0;
        store_operand_x_i = '0;
        address_x_i       = '0;
        address_m_i       = '0;
        address_w_i       = '0;
        lfsr_q            = 32'he9826b9d;
        checks            = 0;
        errors            = 0;
        mark              = 0;
        for (int i = 0; i < 256; i++)
        begin
            r = bus_pattern(i);
            for (int k = 0; k < 4; k++)
                bus_ref[i * 4 + k] = r[(3 - k) * 8 +: 8];
        end

        ////////////////////////////////////////////////////////////////////////
        // Reset
        ////////////////////////////////////////////////////////////////////////
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_bit(d_cyc_o, 1'b0, "cyc after reset");
        check_bit(d_stb_o, 1'b0, "stb after reset");
        check_bit(d_we_o, 1'b0, "we after reset");
        check_bit(stall_wb_load_o, 1'b0, "load stall after reset");
        report_test("reset");

        // Word stores give every RAM word a known value
        for (int i = 0; i < RAM_WORDS; i++)
            run_access(1'b0, SIZE_WORD, 1'b0, i * 4, take_bits(32), 1'b0);
        report_test("ram_fill");

        ////////////////////////////////////////////////////////////////////////
        // Random loads and stores
        ////////////////////////////////////////////////////////////////////////
        for (int t = 0; t < NUM_RANDOM; t++)
        begin : random_access
            logic        in_ram, is_load, sx, kill;
            size_e       s;
            logic [31:0] addr;
            in_ram  = take_bits(1) != 0;
            is_load = take_bits(1) != 0;
            r       = take_bits(2);
            s       = (r[1:0] == 2'd0) ? SIZE_BYTE : (r[1:0] == 2'd1) ? SIZE_HWORD : SIZE_WORD;
            sx      = take_bits(1) != 0;
            addr    = in_ram ? take_bits(8) : BUS_BASE + take_bits(10);
            if (s == SIZE_HWORD) addr[0] = 1'b0;
            if (s == SIZE_WORD) addr[1:0] = 2'b00;
            kill    = is_load && !in_ram && (take_bits(3) == 0);
            run_access(is_load, s, sx, addr, take_bits(32), kill);
        end
        report_test("random_traffic");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* lsu.f */
+incdir+source
source/lsu_pkg.sv
source/lsu_stage_if.sv
source/lsu_xm_stage.sv
source/lsu_dram.sv
source/lsu_wb_master.sv
source/lsu_load_align.sv
source/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lsu.f --top-module lsu_tb -o lsu_sim
output=$(./obj_dir/lsu_sim)
echo "$output"

if grep -q "Simulation passed" <<< "$output"; then
    exit 0
fi
exit 1
